/* Bender.yml */
package:
  name: mips

sources:
  - src/mips_pkg.sv
  - src/fetch_unit.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/memory_writeback.sv
  - src/hazard_unit.sv
  - src/mips.sv
  - target: test
    files:
      - test/mips_tb.sv

/* list.f */
src/mips_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/hazard_unit.sv
src/mips.sv
test/mips_tb.sv

/* src/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::data_width-1:0] if_pc,
    input  logic [mips_pkg::data_width-1:0] if_ir,
    input  logic                            stall,
    input  logic                            flush_ex,
    input  logic                            halted,
    input  logic                            wb_we,
    input  logic [4:0]                      wb_rw,
    input  logic [mips_pkg::data_width-1:0] wb_data,
    input  logic                            mem_reg_we,
    input  logic [4:0]                      mem_rw,
    input  logic [mips_pkg::data_width-1:0] mem_result,
    output logic                            branch_taken,
    output logic [mips_pkg::data_width-1:0] branch_target,
    output logic [4:0]                      id_rs,
    output logic [4:0]                      id_rt,
    output logic                            id_uses_branch_regs,
    output logic [mips_pkg::data_width-1:0] v0_data,
    output logic [mips_pkg::data_width-1:0] a0_data,
    output logic [4:0]                      ex_rs,
    output logic [4:0]                      ex_rt,
    output logic [4:0]                      ex_rw,
    output logic [mips_pkg::data_width-1:0] ex_r1,
    output logic [mips_pkg::data_width-1:0] ex_r2,
    output logic [mips_pkg::data_width-1:0] ex_imm,
    output mips_pkg::alu_op_t               ex_alu_op,
    output logic                            ex_alu_src,
    output logic                            ex_reg_we,
    output logic                            ex_mem_read,
    output logic                            ex_mem_write,
    output logic                            ex_syscall
);
    import mips_pkg::*;

    logic [data_width-1:0] regs [32];
    logic [5:0]            op;
    logic [5:0]            funct;
    logic [4:0]            rd;
    logic [15:0]           imm16;
    logic [data_width-1:0] imm_sext;
    logic [data_width-1:0] r1;
    logic [data_width-1:0] r2;
    logic [data_width-1:0] b1;
    logic [data_width-1:0] b2;
    logic                  reg_we;
    logic                  rtype_dst;
    logic                  alu_src;
    logic                  zero_ext;
    logic                  mem_read;
    logic                  mem_write;
    logic                  syscall;
    logic                  is_beq;
    logic                  is_bne;
    logic                  is_j;
    alu_op_t               alu_op;

    assign op = if_ir[31:26];
    assign id_rs = if_ir[25:21];
    assign id_rt = if_ir[20:16];
    assign rd = if_ir[15:11];
    assign funct = if_ir[5:0];
    assign imm16 = if_ir[15:0];
    assign imm_sext = {{(data_width-16){imm16[15]}}, imm16};

    always_comb begin
        reg_we = 1'b0;
        rtype_dst = 1'b0;
        alu_src = 1'b0;
        zero_ext = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        syscall = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        is_j = 1'b0;
        alu_op = alu_add;
        case (op)
            op_rtype: begin
                rtype_dst = 1'b1;
                reg_we = funct inside {fn_addu, fn_subu, fn_and, fn_or, fn_slt};
                syscall = (funct == fn_syscall);
                case (funct)
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default: alu_op = alu_add;
                endcase
            end
            op_addiu: begin
                reg_we = 1'b1;
                alu_src = 1'b1;
            end
            op_ori: begin
                reg_we = 1'b1;
                alu_src = 1'b1;
                zero_ext = 1'b1;
                alu_op = alu_or;
            end
            op_lui: begin
                reg_we = 1'b1;
                alu_src = 1'b1;
                alu_op = alu_lui;
            end
            op_lw: begin
                reg_we = 1'b1;
                alu_src = 1'b1;
                mem_read = 1'b1;
            end
            op_sw: begin
                alu_src = 1'b1;
                mem_write = 1'b1;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            op_j:    is_j = 1'b1;
            default: ;
        endcase
    end

    // register file, writeback value wins on a same-cycle read
    assign r1 = (wb_we && wb_rw != 5'd0 && wb_rw == id_rs) ? wb_data : regs[id_rs];
    assign r2 = (wb_we && wb_rw != 5'd0 && wb_rw == id_rt) ? wb_data : regs[id_rt];
    assign v0_data = regs[reg_v0];
    assign a0_data = regs[reg_a0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rw != 5'd0) begin
            regs[wb_rw] <= wb_data;
        end
    end

    // branch compare, producer in memory is taken from its result
    assign b1 = (mem_reg_we && mem_rw != 5'd0 && mem_rw == id_rs) ? mem_result : r1;
    assign b2 = (mem_reg_we && mem_rw != 5'd0 && mem_rw == id_rt) ? mem_result : r2;
    assign id_uses_branch_regs = is_beq || is_bne;
    assign branch_taken = !stall && (is_j || (is_beq && b1 == b2) || (is_bne && b1 != b2));
    assign branch_target = is_j ? {if_pc[data_width-1:28], if_ir[25:0], 2'b00}
                                : if_pc + 4 + {imm_sext[data_width-3:0], 2'b00};

    // ID/EX
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_reg_we <= 1'b0;
            ex_mem_read <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_syscall <= 1'b0;
        end else if (!halted) begin
            // stalled instruction leaves a bubble behind
            ex_reg_we <= reg_we && !flush_ex;
            ex_mem_read <= mem_read && !flush_ex;
            ex_mem_write <= mem_write && !flush_ex;
            ex_syscall <= syscall && !flush_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            ex_rs <= id_rs;
            ex_rt <= id_rt;
            ex_rw <= rtype_dst ? rd : id_rt;
            ex_r1 <= r1;
            ex_r2 <= r2;
            ex_imm <= zero_ext ? {{(data_width-16){1'b0}}, imm16} : imm_sext;
            ex_alu_op <= alu_op;
            ex_alu_src <= alu_src;
        end
    end

    // $zero survives any writeback aimed at it
    assert property (@(posedge clk) disable iff (reset)
        wb_we && wb_rw == 5'd0 |=> regs[0] == '0);

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            halted,
    input  mips_pkg::fwd_sel_t              fwd_a,
    input  mips_pkg::fwd_sel_t              fwd_b,
    input  logic [4:0]                      ex_rw,
    input  logic [mips_pkg::data_width-1:0] ex_r1,
    input  logic [mips_pkg::data_width-1:0] ex_r2,
    input  logic [mips_pkg::data_width-1:0] ex_imm,
    input  mips_pkg::alu_op_t               ex_alu_op,
    input  logic                            ex_alu_src,
    input  logic                            ex_reg_we,
    input  logic                            ex_mem_read,
    input  logic                            ex_mem_write,
    input  logic                            ex_syscall,
    input  logic [mips_pkg::data_width-1:0] wb_data,
    output logic [mips_pkg::data_width-1:0] mem_result,
    output logic [mips_pkg::data_width-1:0] mem_wdata,
    output logic [4:0]                      mem_rw,
    output logic                            mem_reg_we,
    output logic                            mem_mem_read,
    output logic                            mem_mem_write,
    output logic                            mem_syscall
);
    import mips_pkg::*;

    logic [data_width-1:0] a;
    logic [data_width-1:0] b_reg;
    logic [data_width-1:0] b;
    logic [data_width-1:0] result;

    function automatic logic [data_width-1:0] pick(fwd_sel_t sel,
                                                   logic [data_width-1:0] reg_val,
                                                   logic [data_width-1:0] mem_val,
                                                   logic [data_width-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign a = pick(fwd_a, ex_r1, mem_result, wb_data);
    assign b_reg = pick(fwd_b, ex_r2, mem_result, wb_data);
    assign b = ex_alu_src ? ex_imm : b_reg;

    always_comb begin
        case (ex_alu_op)
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_slt: result = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            alu_lui: result = {b[15:0], 16'b0};
            default: result = a + b;
        endcase
    end

    // EX/MEM
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_reg_we <= 1'b0;
            mem_mem_read <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_syscall <= 1'b0;
        end else if (!halted) begin
            mem_reg_we <= ex_reg_we;
            mem_mem_read <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_syscall <= ex_syscall;
        end
    end

    // store data is the forwarded rt value
    always_ff @(posedge clk) begin
        if (!halted) begin
            mem_result <= result;
            mem_wdata <= b_reg;
            mem_rw <= ex_rw;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        fwd_a inside {fwd_none, fwd_mem, fwd_wb} && fwd_b inside {fwd_none, fwd_mem, fwd_wb});

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int im_addr_width = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            prog_we,
    input  logic [im_addr_width-1:0]        prog_addr,
    input  logic [mips_pkg::data_width-1:0] prog_data,
    input  logic                            stall,
    input  logic                            halted,
    input  logic                            branch_taken,
    input  logic [mips_pkg::data_width-1:0] branch_target,
    output logic [mips_pkg::data_width-1:0] if_pc,
    output logic [mips_pkg::data_width-1:0] if_ir
);
    import mips_pkg::*;

    logic [data_width-1:0] imem [2**im_addr_width];
    logic [data_width-1:0] pc;
    logic [data_width-1:0] pc_next;
    logic [data_width-1:0] ir;
    logic                  hold;

    assign hold = stall || halted;
    assign ir = imem[pc[im_addr_width+1:2]];
    assign pc_next = branch_taken ? branch_target : pc + 4;

    // program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!hold) begin
            pc <= pc_next;
        end
    end

    // IF/ID, an all-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (reset) begin
            if_ir <= '0;
        end else if (!hold) begin
            if_ir <= branch_taken ? '0 : ir;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if_pc <= pc;
        end
    end

    // program words only go in while the core sits in reset
    assert property (@(posedge clk) prog_we |-> reset);

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    input  logic               id_uses_branch_regs,
    input  logic [4:0]         id_rs,
    input  logic [4:0]         id_rt,
    input  logic [4:0]         ex_rs,
    input  logic [4:0]         ex_rt,
    input  logic [4:0]         ex_rw,
    input  logic               ex_reg_we,
    input  logic               ex_mem_read,
    input  logic [4:0]         mem_rw,
    input  logic               mem_reg_we,
    input  logic               mem_mem_read,
    input  logic [4:0]         wb_rw,
    input  logic               wb_we,
    output logic               stall,
    output logic               flush_ex,
    output mips_pkg::fwd_sel_t fwd_a,
    output mips_pkg::fwd_sel_t fwd_b
);
    import mips_pkg::*;

    logic load_use;
    logic branch_wait;

    // pending write to src, never for $zero
    function automatic logic hits(logic we, logic [4:0] dst, logic [4:0] src);
        return we && dst != 5'd0 && dst == src;
    endfunction

    // memory is younger, so it wins over writeback
    assign fwd_a = hits(mem_reg_we, mem_rw, ex_rs) ? fwd_mem
                 : hits(wb_we, wb_rw, ex_rs) ? fwd_wb : fwd_none;
    assign fwd_b = hits(mem_reg_we, mem_rw, ex_rt) ? fwd_mem
                 : hits(wb_we, wb_rw, ex_rt) ? fwd_wb : fwd_none;

    assign load_use = hits(ex_mem_read, ex_rw, id_rs) || hits(ex_mem_read, ex_rw, id_rt);

    // branch compares in decode, so an ALU result in execute or a load in memory is too late
    assign branch_wait = id_uses_branch_regs
        && (hits(ex_reg_we, ex_rw, id_rs) || hits(ex_reg_we, ex_rw, id_rt)
            || hits(mem_mem_read, mem_rw, id_rs) || hits(mem_mem_read, mem_rw, id_rt));

    assign stall = load_use || branch_wait;
    assign flush_ex = stall;

endmodule

/* src/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback #(
    parameter int dm_addr_width = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [mips_pkg::data_width-1:0] mem_result,
    input  logic [mips_pkg::data_width-1:0] mem_wdata,
    input  logic [4:0]                      mem_rw,
    input  logic                            mem_reg_we,
    input  logic                            mem_mem_read,
    input  logic                            mem_mem_write,
    input  logic                            mem_syscall,
    input  logic [mips_pkg::data_width-1:0] v0_data,
    input  logic [mips_pkg::data_width-1:0] a0_data,
    output logic                            wb_we,
    output logic [4:0]                      wb_rw,
    output logic [mips_pkg::data_width-1:0] wb_data,
    output logic                            out_valid,
    output logic [mips_pkg::data_width-1:0] out_data,
    output logic                            halted
);
    import mips_pkg::*;

    logic [data_width-1:0]    dmem [2**dm_addr_width];
    logic [dm_addr_width-1:0] addr;
    logic [data_width-1:0]    wb_result;
    logic [data_width-1:0]    wb_load_data;
    logic                     wb_mem_read;
    logic                     wb_syscall;
    logic                     halt_q;
    logic                     halt_now;

    assign addr = mem_result[dm_addr_width+1:2];

    // exit in writeback also blocks the store behind it
    always_ff @(posedge clk) begin
        if (mem_mem_write && !halted) begin
            dmem[addr] <= mem_wdata;
        end
    end

    // MEM/WB
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_we <= 1'b0;
            wb_mem_read <= 1'b0;
            wb_syscall <= 1'b0;
        end else if (!halted) begin
            wb_we <= mem_reg_we;
            wb_mem_read <= mem_mem_read;
            wb_syscall <= mem_syscall;
        end
    end

    always_ff @(posedge clk) begin
        if (!halted) begin
            wb_rw <= mem_rw;
            wb_result <= mem_result;
            wb_load_data <= dmem[addr];
        end
    end

    assign wb_data = wb_mem_read ? wb_load_data : wb_result;

    // syscalls act here
    assign halt_now = wb_syscall && v0_data == sys_exit;
    assign halted = halt_q || halt_now;
    assign out_valid = wb_syscall && v0_data == sys_print;
    assign out_data = a0_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            halt_q <= 1'b0;
        end else if (halt_now) begin
            halt_q <= 1'b1;
        end
    end

    // a frozen pipeline prints nothing
    assert property (@(posedge clk) disable iff (reset)
        halted |-> !out_valid);

endmodule

/* src/mips.sv */
`timescale 1ns/1ps

module mips #(
    parameter int im_addr_width = 8,
    parameter int dm_addr_width = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            prog_we,
    input  logic [im_addr_width-1:0]        prog_addr,
    input  logic [mips_pkg::data_width-1:0] prog_data,
    output logic                            out_valid,
    output logic [mips_pkg::data_width-1:0] out_data,
    output logic                            halted
);
    import mips_pkg::*;

    logic [data_width-1:0] if_pc;
    logic [data_width-1:0] if_ir;
    logic                  branch_taken;
    logic [data_width-1:0] branch_target;
    logic                  stall;
    logic                  flush_ex;
    logic [4:0]            id_rs;
    logic [4:0]            id_rt;
    logic                  id_uses_branch_regs;
    logic [data_width-1:0] v0_data;
    logic [data_width-1:0] a0_data;

    // ID/EX
    logic [4:0]            ex_rs;
    logic [4:0]            ex_rt;
    logic [4:0]            ex_rw;
    logic [data_width-1:0] ex_r1;
    logic [data_width-1:0] ex_r2;
    logic [data_width-1:0] ex_imm;
    alu_op_t               ex_alu_op;
    logic                  ex_alu_src;
    logic                  ex_reg_we;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    logic                  ex_syscall;
    fwd_sel_t              fwd_a;
    fwd_sel_t              fwd_b;

    // EX/MEM and writeback bus
    logic [data_width-1:0] mem_result;
    logic [data_width-1:0] mem_wdata;
    logic [4:0]            mem_rw;
    logic                  mem_reg_we;
    logic                  mem_mem_read;
    logic                  mem_mem_write;
    logic                  mem_syscall;
    logic                  wb_we;
    logic [4:0]            wb_rw;
    logic [data_width-1:0] wb_data;

    fetch_unit #(.im_addr_width(im_addr_width)) fetch_inst (
        .clk, .reset, .prog_we, .prog_addr, .prog_data, .stall, .halted,
        .branch_taken, .branch_target, .if_pc, .if_ir
    );

    decode_stage decode_inst (
        .clk, .reset, .if_pc, .if_ir, .stall, .flush_ex, .halted,
        .wb_we, .wb_rw, .wb_data, .mem_reg_we, .mem_rw, .mem_result,
        .branch_taken, .branch_target, .id_rs, .id_rt, .id_uses_branch_regs,
        .v0_data, .a0_data, .ex_rs, .ex_rt, .ex_rw, .ex_r1, .ex_r2, .ex_imm,
        .ex_alu_op, .ex_alu_src, .ex_reg_we, .ex_mem_read, .ex_mem_write, .ex_syscall
    );

    execute_stage execute_inst (
        .clk, .reset, .halted, .fwd_a, .fwd_b, .ex_rw, .ex_r1, .ex_r2, .ex_imm,
        .ex_alu_op, .ex_alu_src, .ex_reg_we, .ex_mem_read, .ex_mem_write, .ex_syscall,
        .wb_data, .mem_result, .mem_wdata, .mem_rw, .mem_reg_we, .mem_mem_read,
        .mem_mem_write, .mem_syscall
    );

    memory_writeback #(.dm_addr_width(dm_addr_width)) memory_inst (
        .clk, .reset, .mem_result, .mem_wdata, .mem_rw, .mem_reg_we, .mem_mem_read,
        .mem_mem_write, .mem_syscall, .v0_data, .a0_data, .wb_we, .wb_rw, .wb_data,
        .out_valid, .out_data, .halted
    );

    hazard_unit hazard_inst (
        .id_uses_branch_regs, .id_rs, .id_rt, .ex_rs, .ex_rt, .ex_rw, .ex_reg_we,
        .ex_mem_read, .mem_rw, .mem_reg_we, .mem_mem_read, .wb_rw, .wb_we,
        .stall, .flush_ex, .fwd_a, .fwd_b
    );

endmodule

/* src/mips_pkg.sv */
package mips_pkg;

    localparam int data_width = 32;

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j = 6'h02;
    localparam logic [5:0] op_beq = 6'h04;
    localparam logic [5:0] op_bne = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_ori = 6'h0d;
    localparam logic [5:0] op_lui = 6'h0f;
    localparam logic [5:0] op_lw = 6'h23;
    localparam logic [5:0] op_sw = 6'h2b;

    // rtype function codes
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or = 6'h25;
    localparam logic [5:0] fn_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    localparam logic [4:0] reg_v0 = 5'd2;
    localparam logic [4:0] reg_a0 = 5'd4;

    // syscall service numbers in v0
    localparam logic [data_width-1:0] sys_print = 32'd1;
    localparam logic [data_width-1:0] sys_exit = 32'd10;

endpackage

/* test/mips_patterns.hex */
// program length N, then N instruction words, then print count M, then M printed words
// instruction words are MIPS encodings, assembly in the trailing comments
00000032
24020001 3c081234 35085678 2509fff8        // v0=1, lui/ori t0=0x12345678, t1=t0-8
01095023 01482021 0000000c                 // subu t2=t0-t1, addu a0=t2+t0, print
01095824 016a2025 0000000c                 // and t3=t0&t1, or a0=t3|t2, print
0128202a 0000000c 240bffff 010b202a 0000000c   // slt t1<t0, print, t3=-1, slt t0<t3, print
24080040 24090123 ad090000 8d0a0000        // t0=0x40, t1=0x123, sw t1 0(t0), lw t2 0(t0)
01492021 0000000c                          // addu a0=t2+t1 right after the load, print
3c0bbeef 356bcafe ad0b0004 8d040004 0000000c   // t3=0xbeefcafe, sw, lw a0, print
24080005 24090005 11090002                 // t0=5, t1=5, beq t0 t1 taken on a fresh t1
24040bad 0000000c                          // skipped
15090002 24040011 0000000c                 // bne not taken, print 0x11
15000002 24040bad 0000000c                 // bne t0 zero taken, skips two
11000002 24040022 0000000c                 // beq t0 zero not taken, print 0x22
0800002b 24040bad 0000000c                 // j word 43, skips two
24040033 0000000c                          // print 0x33
2402000a 0000000c                          // v0=10, exit
24020001 24040bad 0000000c                 // frozen behind the exit
00000009
12345680 12345678 00000001 00000000
00000246 beefcafe
00000011 00000022 00000033

/* test/mips_tb.sv */
`timescale 1ns/1ps

module mips_tb;
    import mips_pkg::*;

    localparam int im_addr_width = 8;
    localparam int dm_addr_width = 8;
    localparam int pattern_depth = 256;
    localparam int settle_cycles = 10;

    logic                     clk;
    logic                     reset;
    logic                     prog_we;
    logic [im_addr_width-1:0] prog_addr;
    logic [data_width-1:0]    prog_data;
    logic                     out_valid;
    logic [data_width-1:0]    out_data;
    logic                     halted;

    logic [data_width-1:0] patterns [pattern_depth];
    int                    prog_len;
    int                    exp_count;
    int                    out_count;
    int                    tests;
    int                    failures;
    bit                    file_ok;

    mips #(
        .im_addr_width(im_addr_width),
        .dm_addr_width(dm_addr_width)
    ) mips_inst (
        .clk, .reset, .prog_we, .prog_addr, .prog_data, .out_valid, .out_data, .halted
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    task automatic finish_test(input string name, input bit ok);
        tests++;
        if (!ok) begin
            failures++;
        end
        $display("%s: %s", name, ok ? "pass" : "fail");
    endtask

    // program words go in one per falling edge, reset still high
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(negedge clk);
            prog_we = 1'b1;
            prog_addr = im_addr_width'(i);
            prog_data = patterns[1 + i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic check_print();
        logic [data_width-1:0] expected;
        string                 name;
        name = $sformatf("print %0d", out_count);
        if (out_count >= exp_count) begin
            $display("unexpected print of 0x%08h after all %0d expected words", out_data,
                     exp_count);
            finish_test(name, 1'b0);
        end else begin
            expected = patterns[prog_len + 2 + out_count];
            if (out_data !== expected) begin
                $display("ERROR out_data: expected 0x%08h, got 0x%08h", expected, out_data);
                finish_test(name, 1'b0);
            end else begin
                finish_test(name, 1'b1);
            end
        end
        out_count++;
    endtask

    task automatic run_program();
        int cycles;
        int cycle_limit;
        bit quiet;
        cycles = 0;
        cycle_limit = 20 * prog_len + 50;
        while (!halted && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
            if (out_valid) begin
                check_print();
            end
        end
        if (!halted) begin
            $display("timeout: the core did not halt within %0d cycles", cycle_limit);
            finish_test("halt", 1'b0);
        end else begin
            // after exit the core must stay halted and silent
            quiet = 1'b1;
            repeat (settle_cycles) begin
                @(negedge clk);
                if (!halted || out_valid) begin
                    quiet = 1'b0;
                end
            end
            if (!quiet) begin
                $display("halted dropped or a print appeared after the exit syscall");
            end
            finish_test("halt", quiet);
        end
        if (out_count != exp_count) begin
            $display("ERROR out_valid count: expected 0x%0h, got 0x%0h", exp_count, out_count);
        end
        finish_test("print count", out_count == exp_count);
    endtask

    initial begin
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        tests = 0;
        failures = 0;
        out_count = 0;
        prog_len = 0;
        exp_count = 0;
        $readmemh("test/mips_patterns.hex", patterns);
        file_ok = !$isunknown(patterns[0]) && patterns[0] > 0 && patterns[0] < pattern_depth - 1;
        if (file_ok) begin
            prog_len = patterns[0];
            file_ok = !$isunknown(patterns[prog_len + 1])
                && prog_len + 2 + patterns[prog_len + 1] <= pattern_depth;
        end
        if (!file_ok) begin
            $display("pattern file is missing or its lengths do not fit the pattern memory");
            finish_test("pattern file", 1'b0);
        end else begin
            exp_count = patterns[prog_len + 1];
            load_program();
            repeat (3) begin
                @(negedge clk);
            end
            reset = 1'b0;
            run_program();
        end
        $display("%0d tests, %0d passed, %0d failed", tests, tests - failures, failures);
        if (failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
